//--- Bender.yml
package:
  name: gb_cart

sources:
  - hdl/cart_pkg.sv
  - hdl/backup_pkg.sv
  - hdl/cart_header.sv
  - hdl/mbc_regs.sv
  - hdl/bank_mapper.sv
  - hdl/cart_ram.sv
  - hdl/backup_sequencer.sv
  - hdl/gb_cart.sv
  - target: test
    files:
      - tests/tb_clock_gen.sv
      - tests/tb_gb_cart.sv

//--- gb_cart.f
hdl/cart_pkg.sv
hdl/backup_pkg.sv
hdl/cart_header.sv
hdl/mbc_regs.sv
hdl/bank_mapper.sv
hdl/cart_ram.sv
hdl/backup_sequencer.sv
hdl/gb_cart.sv
tests/tb_clock_gen.sv
tests/tb_gb_cart.sv

//--- hdl/backup_pkg.sv
// sizes of the battery RAM backup path, shared by the sequencer, cart RAM and top
`default_nettype none

package backup_pkg;

	localparam int LBA_W        = 8;   // sector number
	localparam int SECTOR_WORDS = 256; // 16 bit words per sector

	// word index inside a sector buffer
	localparam int BUFF_ADDR_W = $clog2(SECTOR_WORDS);

	// cartridge RAM seen as words, sector then word
	localparam int BK_WORD_ADDR_W = LBA_W + BUFF_ADDR_W;

endpackage

`default_nettype wire

//--- hdl/backup_sequencer.sv
// save-pending tracking and sector by sector copy of battery RAM to and from storage
`timescale 1ns/1ps
`default_nettype none

module backup_sequencer (
	input  wire                                  clk_sys,
	input  wire                                  reset,
	input  wire                                  dl_cart,
	input  wire                                  img_mounted,
	input  wire                                  img_readonly,
	input  wire                                  has_battery,
	input  wire                                  has_ram,
	input  wire  cart_pkg::mbc_kind_t            mbc_kind,
	input  wire  [backup_pkg::LBA_W-1:0]         file_mask,
	input  wire                                  cram_wr,
	input  wire                                  save_req,
	input  wire                                  load_req,
	output logic [backup_pkg::LBA_W-1:0]         sd_lba,
	output logic                                 sd_rd,
	output logic                                 sd_wr,
	input  wire                                  sd_ack,
	output logic                                 bk_busy,
	output logic                                 bk_loading,
	output logic                                 sav_pending
);

	logic dl_d;
	logic ack_d;
	logic load_d;
	logic save_d;
	logic bk_ena;    // writable image mounted for this cartridge
	logic auto_load; // queued load after download

	wire sav_supported = has_battery & (has_ram | mbc_kind == cart_pkg::MBC_2) & bk_ena;
	wire dl_end  = dl_d & ~dl_cart;
	wire load_go = auto_load | (bk_ena & load_req & ~load_d);
	wire save_go = bk_ena & save_req & ~save_d;
	wire start   = ~bk_busy & (load_go | save_go); // load wins a tie

	// ------------------------------------------------------------------------
	// arming and pending flags
	// ------------------------------------------------------------------------
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dl_d        <= 1'b0;
			bk_ena      <= 1'b0;
			auto_load   <= 1'b0;
			sav_pending <= 1'b0;
		end else begin
			dl_d <= dl_cart;
			if (~dl_d & dl_cart)
				bk_ena <= 1'b0;                    // new cartridge, forget old image
			if (dl_cart & img_mounted & ~img_readonly)
				bk_ena <= 1'b1;
			if (dl_end & sav_supported)
				auto_load <= 1'b1;
			else if (start)
				auto_load <= 1'b0;
			if (cram_wr & sav_supported)
				sav_pending <= 1'b1;
			else if (start)
				sav_pending <= 1'b0;
		end
	end

	// ------------------------------------------------------------------------
	// sector walk, four-phase with the storage host
	// ------------------------------------------------------------------------
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ack_d      <= 1'b0;
			load_d     <= 1'b0;
			save_d     <= 1'b0;
			sd_lba     <= '0;
			sd_rd      <= 1'b0;
			sd_wr      <= 1'b0;
			bk_busy    <= 1'b0;
			bk_loading <= 1'b0;
		end else begin
			ack_d  <= sd_ack;
			load_d <= load_req;
			save_d <= save_req;
			if (~ack_d & sd_ack) begin
				sd_rd <= 1'b0;                     // host took the request
				sd_wr <= 1'b0;
			end
			if (start) begin
				bk_busy    <= 1'b1;
				bk_loading <= load_go;
				sd_lba     <= '0;
				sd_rd      <= load_go;
				sd_wr      <= ~load_go;
			end else if (bk_busy && ack_d && !sd_ack) begin
				if (sd_lba == file_mask) begin     // last sector done
					bk_busy    <= 1'b0;
					bk_loading <= 1'b0;
				end else begin
					sd_lba <= sd_lba + 1'b1;
					sd_rd  <= bk_loading;
					sd_wr  <= ~bk_loading;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/bank_mapper.sv
// combinational address mapping from CPU address to ROM word and cart RAM byte, plus read mux
`timescale 1ns/1ps
`default_nettype none

module bank_mapper (
	input  wire  [cart_pkg::CART_ADDR_W-1:0]     cart_addr,
	input  wire  cart_pkg::rom_bank_t            rom_bank,
	input  wire  cart_pkg::ram_bank_t            ram_bank,
	input  wire                                  mbc1_mode,
	input  wire                                  rtc_mode,
	input  wire                                  ram_enable,
	input  wire  cart_pkg::mbc_kind_t            mbc_kind,
	input  wire  cart_pkg::rom_bank_t            rom_mask,
	input  wire  cart_pkg::ram_bank_t            ram_mask,
	input  wire  [15:0]                          rom_data,
	input  wire  [7:0]                           cram_q, // registered, one cycle late
	output logic [cart_pkg::ROM_WORD_ADDR_W-1:0] rom_addr,
	output logic [cart_pkg::CRAM_ADDR_W-1:0]     cram_addr,
	output logic                                 cram_sel,
	output logic [7:0]                           cart_do
);

	cart_pkg::rom_bank_t bank_sel; // bank register, zero in 0000-3fff
	cart_pkg::rom_bank_t rom_eff;
	cart_pkg::ram_bank_t ram_eff;
	logic [1:0]          bank2;
	logic [6:0]          mbc1_bank;

	assign bank_sel = (cart_addr[15:14] == 2'b00) ? 9'd0 : rom_bank;

	// mbc1 bank2 only reaches 0000-3fff and RAM in mode 1
	assign bank2     = ram_bank[1:0] & {2{cart_addr[14] | mbc1_mode}};
	assign mbc1_bank = {bank2, bank_sel[4:0]} & rom_mask[6:0];

	always_comb begin
		case (mbc_kind)
			cart_pkg::MBC_1: begin
				rom_eff = {2'b00, mbc1_bank};
				ram_eff = {2'b00, bank2 & ram_mask[1:0]};
			end
			cart_pkg::MBC_2: begin
				rom_eff = {2'b00, bank_sel[6:0] & rom_mask[6:0]};
				ram_eff = 4'd0; // single 512 byte area
			end
			cart_pkg::MBC_3: begin
				rom_eff = {2'b00, bank_sel[6:0] & rom_mask[6:0]};
				ram_eff = {2'b00, ram_bank[1:0] & ram_mask[1:0]};
			end
			cart_pkg::MBC_5: begin
				rom_eff = bank_sel & rom_mask; // up to 512 banks
				ram_eff = ram_bank & ram_mask;
			end
			default: begin
				rom_eff = {8'd0, cart_addr[14]}; // 32k linear
				ram_eff = 4'd0;
			end
		endcase
	end

	assign rom_addr  = {rom_eff, cart_addr[13:1]};
	assign cram_addr = {ram_eff, cart_addr[12:0]};
	assign cram_sel  = cart_addr[15:13] == cart_pkg::REG_CRAM;

	always_comb begin
		if (!cram_sel)
			cart_do = cart_addr[0] ? rom_data[15:8] : rom_data[7:0];
		else if (!ram_enable)
			cart_do = 8'hFF;                  // disabled RAM floats high
		else if (mbc_kind == cart_pkg::MBC_2)
			cart_do = {4'hF, cram_q[3:0]};   // 4 bit RAM
		else if (rtc_mode)
			cart_do = 8'h00;                  // no clock contents
		else
			cart_do = cram_q;
	end

endmodule

`default_nettype wire

//--- hdl/cart_header.sv
// latches cartridge header bytes off the download stream and decodes mapper, masks and battery
`timescale 1ns/1ps
`default_nettype none

module cart_header (
	input  wire                          clk_sys,
	input  wire                          dl_cart,
	input  wire                          dl_wr,
	input  wire  [24:0]                  dl_addr, // byte address
	input  wire  [15:0]                  dl_data, // little endian word
	output cart_pkg::mbc_kind_t          mbc_kind,
	output cart_pkg::rom_bank_t          rom_mask,
	output cart_pkg::ram_bank_t          ram_mask,
	output logic [backup_pkg::LBA_W-1:0] file_mask, // last sector of the save file
	output logic                         has_battery,
	output logic                         has_ram
);

	logic [7:0] cart_type;
	logic [7:0] rom_size;
	logic [7:0] ram_size;

	// the words we want all sit in 0x140..0x14f
	wire in_hdr = dl_addr[24:4] == cart_pkg::HDR_CGB_OFS[24:4];

	always_ff @(posedge clk_sys) begin
		if (dl_cart && dl_wr && in_hdr) begin
			if (dl_addr[3:0] == cart_pkg::HDR_TYPE_OFS[3:0])
				cart_type <= dl_data[15:8];
			if (dl_addr[3:0] == cart_pkg::HDR_SIZE_OFS[3:0]) begin
				rom_size <= dl_data[7:0];
				ram_size <= dl_data[15:8];
			end
		end
	end

	always_comb begin
		case (cart_type) inside
			8'h01, 8'h02, 8'h03: mbc_kind = cart_pkg::MBC_1;
			8'h05, 8'h06:        mbc_kind = cart_pkg::MBC_2;
			[8'h0F:8'h13]:       mbc_kind = cart_pkg::MBC_3;
			[8'h19:8'h1E]:       mbc_kind = cart_pkg::MBC_5;
			default:             mbc_kind = cart_pkg::MBC_NONE;
		endcase

		// 2 << n banks
		case (rom_size)
			8'h00:   rom_mask = 9'h001; // 32k, linear
			8'h01:   rom_mask = 9'h003;
			8'h02:   rom_mask = 9'h007;
			8'h03:   rom_mask = 9'h00F;
			8'h04:   rom_mask = 9'h01F;
			8'h05:   rom_mask = 9'h03F;
			8'h06:   rom_mask = 9'h07F;
			8'h07:   rom_mask = 9'h0FF;
			8'h08:   rom_mask = 9'h1FF; // 8M, mbc5 only
			default: rom_mask = 9'h07F; // 0x52..0x54 odd sizes fold into 128 banks
		endcase

		case (ram_size)
			8'h01, 8'h02: ram_mask = 4'h0; // single bank
			8'h03:        ram_mask = 4'h3; // 4 banks
			default:      ram_mask = 4'hF;
		endcase

		if (mbc_kind == cart_pkg::MBC_2)
			file_mask = 8'h00; // 512 nibbles fit one sector
		else if (ram_size == 8'h01)
			file_mask = 8'h03;
		else if (ram_size == 8'h02)
			file_mask = 8'h0F;
		else if (ram_size == 8'h03)
			file_mask = 8'h3F;
		else
			file_mask = 8'hFF;
	end

	assign has_battery = cart_type inside {8'h03, 8'h06, 8'h09, 8'h0D, 8'h10,
		8'h13, 8'h1B, 8'h1E, 8'h22, 8'hFF};
	assign has_ram = ram_size != 8'h00; // mbc2 RAM is on the mapper, seen by the sequencer

endmodule

`default_nettype wire

//--- hdl/cart_pkg.sv
// cartridge-side definitions shared by the header decoder, mapper and top, use by scoped names
`default_nettype none

package cart_pkg;

	// ------------------------------------------------------------------------
	// mapper kinds and bank types
	// ------------------------------------------------------------------------
	typedef enum logic [2:0] {
		MBC_NONE = 3'd0, // plain 32k ROM
		MBC_1    = 3'd1,
		MBC_2    = 3'd2, // 512x4 bit internal RAM
		MBC_3    = 3'd3, // RTC capable
		MBC_5    = 3'd4  // 9 bit ROM bank
	} mbc_kind_t;

	typedef logic [8:0] rom_bank_t; // 16k ROM bank number
	typedef logic [3:0] ram_bank_t; // 8k RAM bank number

	// widths
	localparam int CART_ADDR_W     = 16; // CPU cartridge address
	localparam int ROM_WORD_ADDR_W = 22; // {bank, a13, a12..a1}
	localparam int CRAM_ADDR_W     = 17; // 16 banks of 8k

	// header word byte addresses inside the download
	localparam logic [24:0] HDR_CGB_OFS  = 25'h142; // first header word of interest
	localparam logic [24:0] HDR_TYPE_OFS = 25'h146; // high byte is the cartridge type
	localparam logic [24:0] HDR_SIZE_OFS = 25'h148; // low rom size, high ram size

	// CPU address bits 15..13 per region
	localparam logic [2:0] REG_RAM_EN   = 3'b000; // 0000-1fff
	localparam logic [2:0] REG_ROM_BANK = 3'b001; // 2000-3fff
	localparam logic [2:0] REG_RAM_BANK = 3'b010; // 4000-5fff
	localparam logic [2:0] REG_MODE     = 3'b011; // 6000-7fff
	localparam logic [2:0] REG_CRAM     = 3'b101; // a000-bfff

	localparam logic [3:0] RAM_EN_KEY = 4'hA;

endpackage

`default_nettype wire

//--- hdl/cart_ram.sv
// cartridge RAM as two byte lanes, byte port for the CPU and word port for the backup path
`timescale 1ns/1ps
`default_nettype none

module cart_ram_lane #(
	parameter int ADDR_W = backup_pkg::BK_WORD_ADDR_W
) (
	input  wire              clk_sys,
	input  wire [ADDR_W-1:0] a_addr,
	input  wire              a_wr,
	input  wire [7:0]        a_di,
	output logic [7:0]       a_q,
	input  wire [ADDR_W-1:0] b_addr,
	input  wire              b_wr,
	input  wire [7:0]        b_di,
	output logic [7:0]       b_q
);

	logic [7:0] mem [0:2**ADDR_W-1];

	// true dual port, read before write on each side
	always @(posedge clk_sys) begin
		if (a_wr)
			mem[a_addr] <= a_di;
		a_q <= mem[a_addr];
	end

	always @(posedge clk_sys) begin
		if (b_wr)
			mem[b_addr] <= b_di;
		b_q <= mem[b_addr];
	end

endmodule

module cart_ram (
	input  wire                                  clk_sys,
	input  wire  [cart_pkg::CRAM_ADDR_W-1:0]     cpu_addr,
	input  wire                                  cpu_wr,
	input  wire  [7:0]                           cpu_di,
	output logic [7:0]                           cpu_q,
	input  wire  [backup_pkg::BK_WORD_ADDR_W-1:0] bk_addr,
	input  wire                                  bk_wr,
	input  wire  [15:0]                          bk_di,
	output logic [15:0]                          bk_q
);

	logic [7:0] q_l;
	logic [7:0] q_h;
	logic       odd_q; // lane of the read in flight

	always_ff @(posedge clk_sys)
		odd_q <= cpu_addr[0];

	assign cpu_q = odd_q ? q_h : q_l;

	// even bytes
	cart_ram_lane lane_l (
		.clk_sys (clk_sys),
		.a_addr  (cpu_addr[cart_pkg::CRAM_ADDR_W-1:1]),
		.a_wr    (cpu_wr & ~cpu_addr[0]),
		.a_di    (cpu_di),
		.a_q     (q_l),
		.b_addr  (bk_addr),
		.b_wr    (bk_wr),
		.b_di    (bk_di[7:0]),
		.b_q     (bk_q[7:0])
	);

	// odd bytes
	cart_ram_lane lane_h (
		.clk_sys (clk_sys),
		.a_addr  (cpu_addr[cart_pkg::CRAM_ADDR_W-1:1]),
		.a_wr    (cpu_wr & cpu_addr[0]),
		.a_di    (cpu_di),
		.a_q     (q_h),
		.b_addr  (bk_addr),
		.b_wr    (bk_wr),
		.b_di    (bk_di[15:8]),
		.b_q     (bk_q[15:8])
	);

endmodule

`default_nettype wire

//--- hdl/gb_cart.sv
// cartridge side top: header decode, mapper, cart RAM and battery backup copy
`timescale 1ns/1ps
`default_nettype none

module gb_cart (
	input  wire                                  clk_sys,
	input  wire                                  reset,
	// ROM download
	input  wire                                  dl_cart,
	input  wire                                  dl_wr,
	input  wire  [24:0]                          dl_addr,
	input  wire  [15:0]                          dl_data,
	// CPU bus
	input  wire  [cart_pkg::CART_ADDR_W-1:0]     cart_addr,
	input  wire                                  cart_rd,
	input  wire                                  cart_wr,
	input  wire  [7:0]                           cart_di,
	input  wire                                  cpu_ce,
	output logic [7:0]                           cart_do,
	// ROM word port
	output logic [cart_pkg::ROM_WORD_ADDR_W-1:0] rom_addr,
	input  wire  [15:0]                          rom_data,
	// storage
	input  wire                                  img_mounted,
	input  wire                                  img_readonly,
	input  wire                                  save_req,
	input  wire                                  load_req,
	output logic [backup_pkg::LBA_W-1:0]         sd_lba,
	output logic                                 sd_rd,
	output logic                                 sd_wr,
	input  wire                                  sd_ack,
	input  wire  [backup_pkg::BUFF_ADDR_W-1:0]   sd_buff_addr,
	input  wire                                  sd_buff_wr,
	input  wire  [15:0]                          sd_buff_dout,
	output logic [15:0]                          sd_buff_din,
	output logic                                 bk_busy,
	output logic                                 sav_pending
);

	cart_pkg::mbc_kind_t             mbc_kind;
	cart_pkg::rom_bank_t             rom_mask;
	cart_pkg::ram_bank_t             ram_mask;
	cart_pkg::rom_bank_t             rom_bank;
	cart_pkg::ram_bank_t             ram_bank;
	logic [backup_pkg::LBA_W-1:0]    file_mask;
	logic                            has_battery;
	logic                            has_ram;
	logic                            ram_enable;
	logic                            mbc1_mode;
	logic                            rtc_mode;
	logic [cart_pkg::CRAM_ADDR_W-1:0] cram_addr;
	logic                            cram_sel;
	logic [7:0]                      cram_q;
	logic [7:0]                      map_do;
	logic                            bk_loading;

	wire hold    = dl_cart | bk_loading;  // mapper sits in reset meanwhile
	wire cram_wr = cart_wr & cram_sel;

	assign cart_do = cart_rd ? map_do : 8'hFF; // idle bus reads high

	cart_header hdr_i (
		.clk_sys, .dl_cart, .dl_wr, .dl_addr, .dl_data,
		.mbc_kind, .rom_mask, .ram_mask, .file_mask, .has_battery, .has_ram
	);

	mbc_regs regs_i (
		.clk_sys, .reset, .hold, .cpu_ce, .cart_addr, .cart_wr, .cart_di, .mbc_kind,
		.rom_bank, .ram_bank, .ram_enable, .mbc1_mode, .rtc_mode
	);

	bank_mapper map_i (
		.cart_addr, .rom_bank, .ram_bank, .mbc1_mode, .rtc_mode, .ram_enable, .mbc_kind,
		.rom_mask, .ram_mask, .rom_data, .cram_q, .rom_addr, .cram_addr, .cram_sel,
		.cart_do (map_do)
	);

	// word port indexed by {sector, word}
	cart_ram cram_i (
		.clk_sys,
		.cpu_addr (cram_addr),
		.cpu_wr   (cram_wr),
		.cpu_di   (cart_di),
		.cpu_q    (cram_q),
		.bk_addr  ({sd_lba, sd_buff_addr}),
		.bk_wr    (sd_buff_wr & sd_ack),
		.bk_di    (sd_buff_dout),
		.bk_q     (sd_buff_din)
	);

	backup_sequencer seq_i (
		.clk_sys, .reset, .dl_cart, .img_mounted, .img_readonly, .has_battery, .has_ram,
		.mbc_kind, .file_mask, .cram_wr, .save_req, .load_req, .sd_lba, .sd_rd, .sd_wr,
		.sd_ack, .bk_busy, .bk_loading, .sav_pending
	);

endmodule

`default_nettype wire

//--- hdl/mbc_regs.sv
// mapper control registers written by the CPU into the 0000-7fff region
`timescale 1ns/1ps
`default_nettype none

module mbc_regs (
	input  wire                                  clk_sys,
	input  wire                                  reset,
	input  wire                                  hold, // download or backup load running
	input  wire                                  cpu_ce,
	input  wire  [cart_pkg::CART_ADDR_W-1:0]     cart_addr,
	input  wire                                  cart_wr,
	input  wire  [7:0]                           cart_di,
	input  wire  cart_pkg::mbc_kind_t            mbc_kind,
	output cart_pkg::rom_bank_t                  rom_bank,
	output cart_pkg::ram_bank_t                  ram_bank,
	output logic                                 ram_enable,
	output logic                                 mbc1_mode,
	output logic                                 rtc_mode
);

	wire       wr_en  = cart_wr & cpu_ce;
	wire [2:0] region = cart_addr[15:13];
	wire       is_mbc1 = mbc_kind == cart_pkg::MBC_1;
	wire       is_mbc3 = mbc_kind == cart_pkg::MBC_3;
	wire       is_mbc5 = mbc_kind == cart_pkg::MBC_5;

	// mbc1 bank register is only 5 bits wide
	wire       bank_zero = is_mbc1 ? cart_di[4:0] == 5'd0 : cart_di[6:0] == 7'd0;

	always_ff @(posedge clk_sys) begin
		if (reset || hold) begin
			rom_bank   <= 9'd1;
			ram_bank   <= 4'd0;
			ram_enable <= 1'b0;
			mbc1_mode  <= 1'b0;
			rtc_mode   <= 1'b0;
		end else if (wr_en) begin
			case (region)
				cart_pkg::REG_RAM_EN:
					ram_enable <= cart_di[3:0] == cart_pkg::RAM_EN_KEY; // anything else disables
				cart_pkg::REG_ROM_BANK: begin
					if (is_mbc5) begin
						if (cart_addr[12])
							rom_bank[8] <= cart_di[0];   // 3000-3fff
						else
							rom_bank[7:0] <= cart_di;    // 2000-2fff
					end else if (bank_zero) begin
						rom_bank <= 9'd1;                // bank 0 reads as bank 1
					end else begin
						rom_bank <= {2'b00, cart_di[6:0]};
					end
				end
				cart_pkg::REG_RAM_BANK: begin
					if (is_mbc3 && cart_di[3]) begin
						rtc_mode <= 1'b1;                // rtc register select
					end else if (is_mbc3) begin
						rtc_mode <= 1'b0;
						ram_bank <= {2'b00, cart_di[1:0]};
					end else if (is_mbc5) begin
						ram_bank <= cart_di[3:0];
					end else begin
						ram_bank <= {2'b00, cart_di[1:0]}; // mbc1 bank2 bits
					end
				end
				cart_pkg::REG_MODE:
					if (is_mbc1)
						mbc1_mode <= cart_di[0];
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- tests/tb_clock_gen.sv
// testbench clock and reset source, 100 ns clk_sys with reset held for the first 5 cycles
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
	output logic clk_sys,
	output logic reset
);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys; // 100 ns period
	end

	initial begin
		reset = 1'b1;
		repeat (5) @(posedge clk_sys);
		#10 reset = 0; // released with the other inputs, just after the edge
	end

endmodule

`default_nettype wire

//--- tests/tb_gb_cart.sv
// directed testbench for gb_cart with ROM and storage host models, run as the simulation top
`timescale 1ns/1ps
`default_nettype none

module tb_gb_cart;

	localparam int SECTOR_CYCLES = 300;                // 256 words, host wait and handshake
	localparam int COPY_LIMIT    = 16 * SECTOR_CYCLES; // one 16 sector copy
	localparam int MAX_CYCLES    = 4 * COPY_LIMIT + 800; // three copies, one spare, mapper tests

	logic        clk_sys, reset;
	logic        dl_cart, dl_wr;
	logic [24:0] dl_addr;
	logic [15:0] dl_data;
	logic [15:0] cart_addr;
	logic        cart_rd, cart_wr, cpu_ce;
	logic [7:0]  cart_di, cart_do;
	logic [21:0] rom_addr;
	logic [15:0] rom_data;
	logic        img_mounted, img_readonly, save_req, load_req;
	logic [7:0]  sd_lba, sd_buff_addr;
	logic        sd_rd, sd_wr, sd_ack, sd_buff_wr;
	logic [15:0] sd_buff_dout, sd_buff_din;
	logic        bk_busy, sav_pending;

	int    errors = 0;
	int    checks = 0;
	int    tests  = 0;
	int    cycles = 0;
	string cur_test;

	logic [7:0]  req_lba[$];              // host log, one entry per sector request
	logic        req_load[$];
	logic [15:0] saved_words [0:65535];   // storage image, index {lba, word}

	tb_clock_gen clk_i (.clk_sys, .reset);

	gb_cart dut_i (.*);

	// ------------------------------------------------------------------------
	// models
	// ------------------------------------------------------------------------
	function automatic logic [15:0] rom_word(input logic [21:0] a);
		rom_word = {a[7:0] ^ a[21:14], a[15:8] ^ 8'h5A}; // every bank looks different
	endfunction

	function automatic logic [7:0] rom_byte(input logic [8:0] bank, input logic [15:0] a);
		logic [15:0] w;
		w = rom_word({bank, a[13:1]});
		rom_byte = a[0] ? w[15:8] : w[7:0];
	endfunction

	function automatic logic [15:0] load_word(input logic [7:0] lba, input logic [7:0] w);
		logic [7:0] lo, hi;
		lo = w ^ {lba[4:0], 3'b101};
		hi = ~w + lba;
		load_word = {hi, lo};
	endfunction

	// byte b of cart RAM is half of word b>>1, low half when even
	function automatic logic [7:0] pattern_byte(input int b);
		logic [15:0] w;
		w = load_word(8'(b >> 9), 8'(b >> 1));
		pattern_byte = b[0] ? w[15:8] : w[7:0];
	endfunction

	assign rom_data = rom_word(rom_addr); // same cycle answer

	always @(posedge clk_sys) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: run still going after %0d cycles", cycles);
			$display("Simulation failed");
			$finish;
		end
	end

	task next_cycle();
		@(posedge clk_sys);
		#10;
	endtask

	// storage host, takes one request at a time
	task automatic serve_sector(input logic is_load);
		logic [7:0] lba;
		int         wait_n;
		lba    = sd_lba;
		wait_n = $urandom_range(8, 1);
		req_lba.push_back(lba);
		req_load.push_back(is_load);
		repeat (wait_n) next_cycle();
		sd_ack = 1'b1;
		for (int i = 0; i <= 256; i++) begin
			if (is_load && i < 256) begin
				sd_buff_addr = 8'(i);
				sd_buff_dout = load_word(lba, 8'(i));
				sd_buff_wr   = 1'b1;
			end else if (!is_load) begin
				if (i > 0)
					saved_words[{lba, 8'(i - 1)}] = sd_buff_din; // word asked for last cycle
				sd_buff_addr = 8'(i);
			end
			next_cycle();
		end
		sd_buff_wr = 1'b0;
		sd_ack     = 1'b0;
	endtask

	initial begin
		void'($urandom(32'hdcf6));
		sd_ack       = 1'b0;
		sd_buff_addr = '0;
		sd_buff_wr   = 1'b0;
		sd_buff_dout = '0;
		forever begin
			next_cycle();
			if (sd_rd || sd_wr)
				serve_sector(sd_rd);
		end
	end

	// ------------------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------------------
	task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("CHECK FAILED %s (%s): expected 0x%0h, actual 0x%0h",
				cur_test, what, exp, act);
		end
	endtask

	task automatic finish_test(input int err_before);
		tests++;
		$display("test %s done, %0d errors", cur_test, errors - err_before);
	endtask

	task automatic cpu_write(input logic [15:0] a, input logic [7:0] d);
		cart_addr = a;
		cart_di   = d;
		cart_rd   = 1'b0;
		cart_wr   = 1'b1;
		cpu_ce    = 1'b1;
		next_cycle();               // lands on this edge
		cart_wr = 1'b0;
		cpu_ce  = 1'b0;
	endtask

	task automatic rom_read_check(input logic [15:0] a, input logic [8:0] bank);
		cart_addr = a;
		cart_rd   = 1'b1;
		@(negedge clk_sys);         // combinational path settled
		check($sformatf("bank @%h", a), bank, rom_addr[21:13]);
		check($sformatf("data @%h", a), rom_byte(bank, a), cart_do);
		next_cycle();
	endtask

	task automatic ram_read_check(input logic [15:0] a, input logic [7:0] exp);
		cart_addr = a;
		cart_rd   = 1'b1;
		next_cycle();
		next_cycle();               // registered read, two cycles after the address
		check($sformatf("ram @%h", a), exp, cart_do);
	endtask

	task automatic send_word(input logic [24:0] a, input logic [15:0] d);
		dl_addr = a;
		dl_data = d;
		dl_wr   = 1'b1;
		next_cycle();
		dl_wr = 1'b0;
		next_cycle();
	endtask

	task automatic load_header(input logic [7:0] ctype, input logic [7:0] rsize,
		input logic [7:0] asize);
		dl_cart = 1'b1;
		send_word(cart_pkg::HDR_TYPE_OFS, {ctype, 8'h00});
		send_word(cart_pkg::HDR_SIZE_OFS, {asize, rsize});
		dl_cart = 1'b0;
		next_cycle();
	endtask

	// bk_busy up, then down again
	task automatic wait_copy();
		int n;
		n = 0;
		while (!bk_busy && n < 10) begin
			next_cycle();
			n++;
		end
		if (!bk_busy) begin
			errors++;
			$display("%s: backup copy never started", cur_test);
		end else begin
			n = 0;
			while (bk_busy && n < COPY_LIMIT) begin
				next_cycle();
				n++;
			end
			if (bk_busy) begin
				errors++;
				$display("%s: backup copy still busy after %0d cycles", cur_test, n);
			end
		end
	endtask

	task automatic check_log(input logic is_load);
		check("sector count", 16, req_lba.size());
		foreach (req_lba[i]) begin
			check($sformatf("lba of request %0d", i), i, req_lba[i]);
			check($sformatf("direction of request %0d", i), is_load, req_load[i]);
		end
		req_lba.delete();
		req_load.delete();
	endtask

	// ------------------------------------------------------------------------
	// tests
	// ------------------------------------------------------------------------
	task automatic test_mbc1_banking();
		int e;
		e = errors;
		cur_test = "mbc1_banking";
		load_header(8'h01, 8'h04, 8'h00); // 32 banks
		cpu_write(16'h2000, 8'h05);
		rom_read_check(16'h4000, 9'd5);
		rom_read_check(16'h0000, 9'd0);
		rom_read_check(16'h5A31, 9'd5);   // odd byte
		cpu_write(16'h2000, 8'h00);
		rom_read_check(16'h4000, 9'd1);   // bank 0 becomes 1
		cpu_write(16'h2000, 8'h20);
		rom_read_check(16'h4000, 9'd1);   // only 5 register bits, still bank 0
		cpu_write(16'h2000, 8'h25);
		rom_read_check(16'h7FFF, 9'd5);   // masked to 32 banks
		finish_test(e);
	endtask

	task automatic test_mbc5_bank9();
		int e;
		e = errors;
		cur_test = "mbc5_bank9";
		load_header(8'h19, 8'h08, 8'h00);
		cpu_write(16'h2000, 8'h34);
		cpu_write(16'h3000, 8'h01);
		rom_read_check(16'h4000, 9'h134);
		rom_read_check(16'h6ABD, 9'h134);
		rom_read_check(16'h1235, 9'h000);
		finish_test(e);
	endtask

	task automatic test_cram_access();
		int e;
		e = errors;
		cur_test = "cram_access";
		load_header(8'h12, 8'h01, 8'h03); // mbc3, 4 RAM banks
		ram_read_check(16'hA005, 8'hFF);  // still disabled
		cpu_write(16'h0000, 8'h0A);
		cpu_write(16'h4000, 8'h00);
		cpu_write(16'hA005, 8'h11);
		cpu_write(16'hA006, 8'h22);
		cpu_write(16'h4000, 8'h02);
		cpu_write(16'hA005, 8'h33);
		cpu_write(16'hA006, 8'h44);
		ram_read_check(16'hA005, 8'h33);
		ram_read_check(16'hA006, 8'h44);
		cpu_write(16'h4000, 8'h00);
		ram_read_check(16'hA005, 8'h11);
		ram_read_check(16'hA006, 8'h22);
		cpu_write(16'h4000, 8'h08);       // rtc register select
		ram_read_check(16'hA005, 8'h00);
		finish_test(e);
	endtask

	task automatic test_auto_load();
		int e;
		int n;
		e = errors;
		cur_test = "auto_load";
		img_mounted  = 1'b1;
		img_readonly = 1'b0;
		load_header(8'h03, 8'h00, 8'h02); // mbc1 with battery, 8k RAM
		n = 0;
		while (!sd_rd && n < 10) begin
			next_cycle();
			n++;
		end
		check("sd_rd without request", 1, sd_rd);
		check("first lba", 0, sd_lba);
		wait_copy();
		check_log(1'b1);
		finish_test(e);
	endtask

	task automatic test_save();
		int e;
		e = errors;
		cur_test = "save";
		check("sav_pending before write", 0, sav_pending);
		cpu_write(16'h0000, 8'h0A);
		cpu_write(16'hA000, 8'h5A);
		check("sav_pending after write", 1, sav_pending);
		cpu_write(16'hA001, 8'hC3);
		cpu_write(16'hA3FF, 8'h77);
		cpu_write(16'hBFFE, 8'h12);
		save_req = 1'b1;
		next_cycle();
		save_req = 1'b0;
		wait_copy();
		check_log(1'b0);
		check("word 0", 16'hC35A, saved_words[0]);
		check("byte 3ff", 8'h77, saved_words[16'h3FF >> 1][15:8]);
		check("byte 3fe", pattern_byte(16'h3FE), saved_words[16'h3FF >> 1][7:0]);
		check("byte 1ffe", 8'h12, saved_words[16'h1FFE >> 1][7:0]);
		check("untouched word", load_word(8'd5, 8'd17), saved_words[{8'd5, 8'd17}]);
		check("sav_pending at end", 0, sav_pending);
		check("bk_busy at end", 0, bk_busy);
		finish_test(e);
	endtask

	task automatic test_load();
		int e;
		e = errors;
		cur_test = "load";
		load_req = 1'b1;
		next_cycle();
		load_req = 1'b0;
		wait_copy();
		check_log(1'b1);
		cpu_write(16'h0000, 8'h0A);       // mapper was held through the load
		ram_read_check(16'hA000, pattern_byte(16'h0000));
		ram_read_check(16'hA001, pattern_byte(16'h0001));
		ram_read_check(16'hA3FF, pattern_byte(16'h03FF));
		ram_read_check(16'hB235, pattern_byte(16'h1235));
		ram_read_check(16'hBFFE, pattern_byte(16'h1FFE));
		finish_test(e);
	endtask

	initial begin
		dl_cart      = 1'b0;
		dl_wr        = 1'b0;
		dl_addr      = '0;
		dl_data      = '0;
		cart_addr    = '0;
		cart_rd      = 1'b0;
		cart_wr      = 1'b0;
		cart_di      = '0;
		cpu_ce       = 1'b0;
		img_mounted  = 1'b0;
		img_readonly = 1'b0;
		save_req     = 1'b0;
		load_req     = 1'b0;
		wait (!reset);
		next_cycle();
		test_mbc1_banking();
		test_mbc5_bank9();
		test_cram_access();
		test_auto_load();
		test_save();
		test_load();
		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire
